/* source/cr16_macros.svh */
`ifndef CR16_MACROS_SVH
`define CR16_MACROS_SVH

// Machine word and register file geometry
`define CR16_DATA_W    16
`define CR16_REG_IDX_W 4
`define CR16_NUM_REGS  16

// Status register holds N, Z, F, L and C
`define CR16_FLAG_W    5

// First fetch address after reset
`define CR16_RESET_PC  16'h0000

// Instruction field positions
// Major opcode
`define CR16_OP_FIELD  15:12
// Destination register, also the branch condition
`define CR16_RD_FIELD  11:8
// Opcode extension for the 0000 and 1111 classes
`define CR16_EXT_FIELD 7:4
// Source register
`define CR16_RS_FIELD  3:0
// 8-bit immediate or branch displacement
`define CR16_IMM_FIELD 7:0

`endif

/* source/cr16_pkg.sv */
`default_nettype none

`include "cr16_macros.svh"

package cr16_pkg;

    // Major opcode, bits 15:12
    typedef enum logic [3:0] {
        OP_EXT0  = 4'b0000,
        OP_ADDI  = 4'b0001,
        OP_ADDCI = 4'b0010,
        OP_SUBI  = 4'b0100,
        OP_CMPI  = 4'b0101,
        OP_ANDI  = 4'b0111,
        OP_ORI   = 4'b1000,
        OP_XORI  = 4'b1001,
        OP_MOVIL = 4'b1010,
        OP_MOVIU = 4'b1011,
        OP_BCOND = 4'b1100,
        OP_CALLD = 4'b1101,
        OP_EXT1  = 4'b1111
    } opcode_e;

    // Major opcode concatenated with the extension field
    typedef enum logic [7:0] {
        OPX_ADD   = 8'b0000_0000,
        OPX_ADDC  = 8'b0000_0001,
        OPX_SUB   = 8'b0000_0011,
        OPX_CMP   = 8'b0000_0100,
        OPX_AND   = 8'b0000_0110,
        OPX_OR    = 8'b0000_0111,
        OPX_XOR   = 8'b0000_1000,
        OPX_MOV   = 8'b1111_0001,
        OPX_JCOND = 8'b1111_0010,
        OPX_LOAD  = 8'b1111_1010,
        OPX_STORE = 8'b1111_1011
    } opcode_ext_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADDC, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC, COND_FS, COND_FC, COND_LT, COND_LE,
        COND_LO, COND_LS, COND_GT, COND_GE, COND_HI, COND_HS, COND_UC
    } cond_e;

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXECUTE, S_MEM, S_WRITEBACK
    } cpu_state_e;

    typedef enum logic [2:0] {
        KIND_ALU, KIND_MOV, KIND_LOAD, KIND_STORE, KIND_BRANCH, KIND_JUMP, KIND_NOP
    } instr_kind_e;

    // Bit 4 down to bit 0, same indices as the status register
    typedef struct packed {
        logic negative;
        logic zero;
        logic flag;
        logic low;
        logic carry;
    } status_flags_t;

    typedef struct packed {
        logic [`CR16_DATA_W-1:0] addr;
        logic [`CR16_DATA_W-1:0] wdata;
        logic                    we;
    } mem_req_t;

    typedef struct packed {
        alu_op_e                    alu_op;
        logic                       use_imm;
        logic [`CR16_DATA_W-1:0]    imm;
        logic [`CR16_REG_IDX_W-1:0] ra;
        logic [`CR16_REG_IDX_W-1:0] rb;
        logic                       writes_rd;
        logic                       updates_flags;
        instr_kind_e                kind;
        logic                       branch_taken;
        logic [`CR16_DATA_W-1:0]    disp;
    } dec_ctrl_t;

endpackage

`default_nettype wire

/* source/cr16_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cr16_macros.svh"

module cr16_decoder (
    input  wire logic [`CR16_DATA_W-1:0] instr,
    input  wire cr16_pkg::status_flags_t flags,
    output cr16_pkg::dec_ctrl_t          ctrl
);
    import cr16_pkg::*;

    opcode_e     op;
    opcode_ext_e opx;
    cond_e       cond;
    logic [7:0]  imm8;
    logic        cond_true;

    assign op   = opcode_e'(instr[`CR16_OP_FIELD]);
    assign opx  = opcode_ext_e'({instr[`CR16_OP_FIELD], instr[`CR16_EXT_FIELD]});
    assign cond = cond_e'(instr[`CR16_RD_FIELD]);
    assign imm8 = instr[`CR16_IMM_FIELD];

    // Condition field against the current status register
    always_comb begin
        case (cond)
            COND_EQ: cond_true = flags.zero;
            COND_NE: cond_true = ~flags.zero;
            COND_CS: cond_true = flags.carry;
            COND_CC: cond_true = ~flags.carry;
            COND_FS: cond_true = flags.flag;
            COND_FC: cond_true = ~flags.flag;
            COND_LT: cond_true = ~flags.negative & ~flags.zero;
            COND_LE: cond_true = ~flags.negative;
            COND_LO: cond_true = ~flags.low & ~flags.zero;
            COND_LS: cond_true = ~flags.low;
            COND_GT: cond_true = flags.negative;
            COND_GE: cond_true = flags.negative | flags.zero;
            COND_HI: cond_true = flags.low;
            COND_HS: cond_true = flags.low | flags.zero;
            COND_UC: cond_true = 1'b1;
            default: cond_true = 1'b0;
        endcase
    end

    always_comb begin
        ctrl              = '0;
        ctrl.alu_op       = ALU_PASS_B;
        ctrl.kind         = KIND_NOP;
        ctrl.ra           = instr[`CR16_RS_FIELD];
        ctrl.rb           = instr[`CR16_RD_FIELD];
        ctrl.branch_taken = cond_true;
        ctrl.disp         = {{8{imm8[7]}}, imm8};
        if (op == OP_EXT0 || op == OP_EXT1) begin
            case (opx)
                OPX_ADD, OPX_ADDC, OPX_SUB, OPX_CMP, OPX_AND, OPX_OR, OPX_XOR: begin
                    ctrl.kind          = KIND_ALU;
                    ctrl.updates_flags = 1'b1;
                    // CMP only sets flags
                    ctrl.writes_rd     = (opx != OPX_CMP);
                    case (opx)
                        OPX_ADD:  ctrl.alu_op = ALU_ADD;
                        OPX_ADDC: ctrl.alu_op = ALU_ADDC;
                        OPX_AND:  ctrl.alu_op = ALU_AND;
                        OPX_OR:   ctrl.alu_op = ALU_OR;
                        OPX_XOR:  ctrl.alu_op = ALU_XOR;
                        default:  ctrl.alu_op = ALU_SUB;
                    endcase
                end
                OPX_MOV: begin
                    ctrl.kind      = KIND_MOV;
                    ctrl.writes_rd = 1'b1;
                end
                OPX_JCOND: ctrl.kind = KIND_JUMP;
                OPX_LOAD: begin
                    ctrl.kind      = KIND_LOAD;
                    ctrl.writes_rd = 1'b1;
                end
                OPX_STORE: begin
                    // Address comes from the destination field, data from the source
                    ctrl.kind = KIND_STORE;
                    ctrl.ra   = instr[`CR16_RD_FIELD];
                    ctrl.rb   = instr[`CR16_RS_FIELD];
                end
                default: ctrl.kind = KIND_NOP;
            endcase
        end else begin
            case (op)
                OP_ADDI, OP_ADDCI, OP_SUBI, OP_CMPI, OP_ANDI, OP_ORI, OP_XORI: begin
                    ctrl.kind          = KIND_ALU;
                    ctrl.updates_flags = 1'b1;
                    ctrl.writes_rd     = (op != OP_CMPI);
                    ctrl.use_imm       = 1'b1;
                    ctrl.imm           = {{8{imm8[7]}}, imm8};
                    case (op)
                        OP_ADDI:  ctrl.alu_op = ALU_ADD;
                        OP_ADDCI: ctrl.alu_op = ALU_ADDC;
                        OP_SUBI, OP_CMPI: ctrl.alu_op = ALU_SUB;
                        default: begin
                            // Logic immediates are zero extended
                            ctrl.imm    = {8'h00, imm8};
                            ctrl.alu_op = (op == OP_ANDI) ? ALU_AND :
                                          (op == OP_ORI)  ? ALU_OR : ALU_XOR;
                        end
                    endcase
                end
                OP_MOVIL, OP_MOVIU: begin
                    // Register A reads the destination so control can merge into it
                    ctrl.kind      = KIND_MOV;
                    ctrl.writes_rd = 1'b1;
                    ctrl.use_imm   = 1'b1;
                    ctrl.imm       = {8'h00, imm8};
                    ctrl.ra        = instr[`CR16_RD_FIELD];
                end
                OP_BCOND: ctrl.kind = KIND_BRANCH;
                OP_CALLD: ctrl.kind = KIND_NOP;
                default:  ctrl.kind = KIND_NOP;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/cr16_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cr16_macros.svh"

module cr16_control (
    input  wire logic                       I_CLK,
    input  wire logic                       I_NRESET,
    input  wire logic                       enable,
    input  wire logic [`CR16_DATA_W-1:0]    mem_rdata,
    input  wire cr16_pkg::dec_ctrl_t        ctrl,
    input  wire logic [`CR16_DATA_W-1:0]    reg_a,
    input  wire logic [`CR16_DATA_W-1:0]    alu_result,
    input  wire cr16_pkg::status_flags_t    alu_flags,
    output logic [`CR16_DATA_W-1:0]         instr,
    output logic [`CR16_REG_IDX_W-1:0]      ra_sel,
    output logic [`CR16_REG_IDX_W-1:0]      rb_sel,
    output logic                            reg_we,
    output logic [`CR16_REG_IDX_W-1:0]      reg_widx,
    output logic [`CR16_DATA_W-1:0]         reg_wdata,
    output cr16_pkg::mem_req_t              mem_req,
    output cr16_pkg::status_flags_t         status_flags,
    output logic [`CR16_DATA_W-1:0]         pc
);
    import cr16_pkg::*;

    cpu_state_e              state;
    cpu_state_e              decode_next;
    logic [`CR16_DATA_W-1:0] load_data;
    logic [`CR16_DATA_W-1:0] mov_value;

    // Where an instruction goes after DECODE
    always_comb begin
        case (ctrl.kind)
            KIND_ALU, KIND_MOV:     decode_next = S_EXECUTE;
            KIND_BRANCH, KIND_JUMP: decode_next = ctrl.branch_taken ? S_EXECUTE : S_FETCH;
            KIND_LOAD, KIND_STORE:  decode_next = S_MEM;
            default:                decode_next = S_FETCH;
        endcase
    end

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            state        <= S_FETCH;
            pc           <= `CR16_RESET_PC;
            instr        <= '0;
            status_flags <= status_flags_t'({`CR16_FLAG_W{1'b0}});
        end else if (enable) begin
            case (state)
                S_FETCH: begin
                    instr <= mem_rdata;
                    pc    <= pc + `CR16_DATA_W'(1);
                    state <= S_DECODE;
                end
                S_DECODE: state <= decode_next;
                S_EXECUTE: begin
                    if (ctrl.updates_flags)
                        status_flags <= alu_flags;
                    // Branch displacement is relative to the already incremented PC
                    if (ctrl.kind == KIND_BRANCH)
                        pc <= pc + ctrl.disp;
                    else if (ctrl.kind == KIND_JUMP)
                        pc <= reg_a;
                    state <= S_FETCH;
                end
                S_MEM: state <= (ctrl.kind == KIND_LOAD) ? S_WRITEBACK : S_FETCH;
                default: state <= S_FETCH;
            endcase
        end
    end

    // Read data is held for the write-back cycle
    always_ff @(posedge I_CLK) begin
        if (enable && state == S_MEM)
            load_data <= mem_rdata;
    end

    // MOV copies A, MOVIL and MOVIU replace one byte of the destination
    always_comb begin
        if (!ctrl.use_imm)
            mov_value = reg_a;
        else if (opcode_e'(instr[`CR16_OP_FIELD]) == OP_MOVIU)
            mov_value = {ctrl.imm[7:0], reg_a[7:0]};
        else
            mov_value = {reg_a[15:8], ctrl.imm[7:0]};
    end

    assign ra_sel   = ctrl.ra;
    assign rb_sel   = ctrl.rb;
    assign reg_widx = ctrl.rb;
    assign reg_we   = enable && ctrl.writes_rd &&
                      (state == S_EXECUTE || state == S_WRITEBACK);

    always_comb begin
        case (ctrl.kind)
            KIND_LOAD: reg_wdata = load_data;
            KIND_MOV:  reg_wdata = mov_value;
            default:   reg_wdata = alu_result;
        endcase
    end

    // Store data is register B routed through the ALU
    always_comb begin
        mem_req = '0;
        if (state == S_FETCH) begin
            mem_req.addr = pc;
        end else if (state == S_MEM) begin
            mem_req.addr = reg_a;
            if (ctrl.kind == KIND_STORE) begin
                mem_req.wdata = alu_result;
                mem_req.we    = enable;
            end
        end
    end

endmodule

`default_nettype wire

/* source/cr16_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cr16_macros.svh"

module cr16_regfile (
    input  wire logic                       I_CLK,
    input  wire logic                       I_NRESET,
    input  wire logic                       enable,
    input  wire logic [`CR16_REG_IDX_W-1:0] ra_sel,
    input  wire logic [`CR16_REG_IDX_W-1:0] rb_sel,
    input  wire logic                       we,
    input  wire logic [`CR16_REG_IDX_W-1:0] widx,
    input  wire logic [`CR16_DATA_W-1:0]    wdata,
    output logic [`CR16_DATA_W-1:0]         a,
    output logic [`CR16_DATA_W-1:0]         b
);

    logic [`CR16_DATA_W-1:0] regs [`CR16_NUM_REGS];

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            for (int i = 0; i < `CR16_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (enable && we) begin
            regs[widx] <= wdata;
        end
    end

    // Both read ports are asynchronous
    assign a = regs[ra_sel];
    assign b = regs[rb_sel];

endmodule

`default_nettype wire

/* source/cr16_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cr16_macros.svh"

module cr16_alu (
    input  wire logic [`CR16_DATA_W-1:0] a,
    input  wire logic [`CR16_DATA_W-1:0] b,
    input  wire logic [`CR16_DATA_W-1:0] imm,
    input  wire logic                    use_imm,
    input  wire cr16_pkg::alu_op_e       op,
    input  wire logic                    carry_in,
    output logic [`CR16_DATA_W-1:0]      result,
    output cr16_pkg::status_flags_t      flags
);
    import cr16_pkg::*;

    localparam int MSB = `CR16_DATA_W - 1;

    logic [`CR16_DATA_W-1:0] opa;
    logic [`CR16_DATA_W:0]   sum;

    // B is the destination operand, A is the source or the immediate
    assign opa = use_imm ? imm : a;

    always_comb begin
        case (op)
            ALU_ADD:    sum = {1'b0, b} + {1'b0, opa};
            ALU_ADDC:   sum = {1'b0, b} + {1'b0, opa} + {{`CR16_DATA_W{1'b0}}, carry_in};
            ALU_SUB:    sum = {1'b0, b} - {1'b0, opa};
            ALU_AND:    sum = {1'b0, b & opa};
            ALU_OR:     sum = {1'b0, b | opa};
            ALU_XOR:    sum = {1'b0, b ^ opa};
            ALU_PASS_B: sum = {1'b0, b};
            default:    sum = '0;
        endcase
    end

    assign result = sum[MSB:0];

    always_comb begin
        flags          = '0;
        // Comparison flags follow every operation
        flags.zero     = (opa == b);
        flags.low      = (b < opa);
        flags.negative = ($signed(b) < $signed(opa));
        case (op)
            ALU_ADD, ALU_ADDC: begin
                flags.carry = sum[`CR16_DATA_W];
                flags.flag  = (b[MSB] == opa[MSB]) && (result[MSB] != b[MSB]);
            end
            ALU_SUB: begin
                // Top bit of the difference is the borrow
                flags.carry = sum[`CR16_DATA_W];
                flags.flag  = (b[MSB] != opa[MSB]) && (result[MSB] != b[MSB]);
            end
            default: begin
                flags.carry = 1'b0;
                flags.flag  = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/cr16_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cr16_macros.svh"

module cr16_core (
    input  wire logic                    I_CLK,
    input  wire logic                    I_NRESET,
    input  wire logic                    enable,
    input  wire logic [`CR16_DATA_W-1:0] mem_rdata,
    output wire cr16_pkg::mem_req_t      mem_req,
    output wire logic [`CR16_DATA_W-1:0] result_bus,
    output wire cr16_pkg::status_flags_t status_flags,
    output wire logic [`CR16_DATA_W-1:0] pc
);
    import cr16_pkg::*;

    logic [`CR16_DATA_W-1:0]    instr;
    dec_ctrl_t                  ctrl;
    logic [`CR16_REG_IDX_W-1:0] ra_sel;
    logic [`CR16_REG_IDX_W-1:0] rb_sel;
    logic                       reg_we;
    logic [`CR16_REG_IDX_W-1:0] reg_widx;
    logic [`CR16_DATA_W-1:0]    reg_wdata;
    logic [`CR16_DATA_W-1:0]    reg_a;
    logic [`CR16_DATA_W-1:0]    reg_b;
    status_flags_t              alu_flags;

    cr16_control i_control (
        .I_CLK        (I_CLK),
        .I_NRESET     (I_NRESET),
        .enable       (enable),
        .mem_rdata    (mem_rdata),
        .ctrl         (ctrl),
        .reg_a        (reg_a),
        .alu_result   (result_bus),
        .alu_flags    (alu_flags),
        .instr        (instr),
        .ra_sel       (ra_sel),
        .rb_sel       (rb_sel),
        .reg_we       (reg_we),
        .reg_widx     (reg_widx),
        .reg_wdata    (reg_wdata),
        .mem_req      (mem_req),
        .status_flags (status_flags),
        .pc           (pc)
    );

    // Branch decisions use the latched status register
    cr16_decoder i_decoder (
        .instr (instr),
        .flags (status_flags),
        .ctrl  (ctrl)
    );

    cr16_regfile i_regfile (
        .I_CLK    (I_CLK),
        .I_NRESET (I_NRESET),
        .enable   (enable),
        .ra_sel   (ra_sel),
        .rb_sel   (rb_sel),
        .we       (reg_we),
        .widx     (reg_widx),
        .wdata    (reg_wdata),
        .a        (reg_a),
        .b        (reg_b)
    );

    cr16_alu i_alu (
        .a        (reg_a),
        .b        (reg_b),
        .imm      (ctrl.imm),
        .use_imm  (ctrl.use_imm),
        .op       (ctrl.alu_op),
        .carry_in (status_flags.carry),
        .result   (result_bus),
        .flags    (alu_flags)
    );

endmodule

`default_nettype wire

/* dv/cr16_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cr16_macros.svh"

module cr16_sva (
    input wire logic                    I_CLK,
    input wire logic                    I_NRESET,
    input wire logic                    enable,
    input wire logic [2:0]              state,
    input wire cr16_pkg::mem_req_t      mem_req,
    input wire logic                    reg_we,
    input wire logic [`CR16_DATA_W-1:0] pc
);
    import cr16_pkg::*;

    state_legal: assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        state inside {S_FETCH, S_DECODE, S_EXECUTE, S_MEM, S_WRITEBACK})
        else $error("illegal control state %0d", state);

    we_only_in_mem: assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        mem_req.we |-> state == S_MEM)
        else $error("memory write outside MEM");

    we_low_when_idle: assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        !enable |-> !mem_req.we)
        else $error("memory write while enable is low");

    no_reg_write_early: assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        (state == S_FETCH || state == S_DECODE) |-> !reg_we)
        else $error("register write in FETCH or DECODE");

    // Reset values hold while reset is applied
    reset_values: assert property (@(posedge I_CLK)
        !I_NRESET |-> (state == S_FETCH && pc == `CR16_RESET_PC && !mem_req.we))
        else $error("wrong state or pc during reset");

endmodule

bind cr16_control cr16_sva i_sva (
    .I_CLK    (I_CLK),
    .I_NRESET (I_NRESET),
    .enable   (enable),
    .state    (state),
    .mem_req  (mem_req),
    .reg_we   (reg_we),
    .pc       (pc)
);

`default_nettype wire

/* dv/cr16_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cr16_macros.svh"

module cr16_tb;
    import cr16_pkg::*;

    logic                    I_CLK;
    logic                    I_NRESET;
    logic                    enable;
    logic [`CR16_DATA_W-1:0] mem_rdata;
    mem_req_t                mem_req;
    logic [`CR16_DATA_W-1:0] result_bus;
    status_flags_t           status_flags;
    logic [`CR16_DATA_W-1:0] pc;

    logic [15:0] mem [256];
    logic [15:0] image [256];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    integer      seed = 18938;
    int          pc_w;
    int          store_cnt;
    logic [15:0] halt_addr;

    cr16_core i_cr16_core (
        .I_CLK        (I_CLK),
        .I_NRESET     (I_NRESET),
        .enable       (enable),
        .mem_rdata    (mem_rdata),
        .mem_req      (mem_req),
        .result_bus   (result_bus),
        .status_flags (status_flags),
        .pc           (pc)
    );

    initial begin
        I_CLK = 1'b0;
        forever #4 I_CLK = ~I_CLK;
    end

    // Single-port memory with combinational read
    assign mem_rdata = mem[mem_req.addr[7:0]];

    always @(posedge I_CLK) begin
        if (mem_req.we)
            mem[mem_req.addr[7:0]] <= mem_req.wdata;
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic emit(input logic [15:0] w);
        image[pc_w[7:0]] = w;
        pc_w++;
    endtask

    function automatic logic [15:0] enc(input logic [3:0] op, input logic [3:0] rd,
                                        input logic [7:0] low);
        return {op, rd, low};
    endfunction

    // STORE [r2], rs then advance the store pointer
    task automatic store_reg(input logic [3:0] rs);
        emit(enc(4'hF, 4'd2, {4'hB, rs}));
        emit(enc(4'h1, 4'd2, 8'h01));
    endtask

    // Compare, then leave mark on fall-through or mark+1 when taken
    task automatic cmp_branch(input logic [15:0] cmpw, input logic [3:0] cond,
                              input logic [7:0] mark);
        emit(cmpw);
        emit(enc(4'hC, cond, 8'h02));
        emit(enc(4'hA, 4'd15, mark));
        emit(enc(4'hC, 4'hE, 8'h01));
        emit(enc(4'hA, 4'd15, mark + 8'd1));
        store_reg(4'd15);
    endtask

    function automatic logic [20:0] alu_ref(input int sel, input logic [15:0] b,
                                            input logic [15:0] a, input logic cin);
        logic [16:0] s;
        logic        c;
        logic        f;
        s = '0;
        c = 1'b0;
        f = 1'b0;
        case (sel)
            0: s = {1'b0, b} + {1'b0, a};
            1: s = {1'b0, b} + {1'b0, a} + {16'd0, cin};
            2: s = {1'b0, b} - {1'b0, a};
            3: s = {1'b0, b & a};
            4: s = {1'b0, b | a};
            default: s = {1'b0, b ^ a};
        endcase
        if (sel <= 1) begin
            c = s[16];
            f = (b[15] == a[15]) && (s[15] != b[15]);
        end else if (sel == 2) begin
            c = b < a;
            f = (b[15] != a[15]) && (s[15] != b[15]);
        end
        // Flags packed N Z F L C
        return {$signed(b) < $signed(a), a == b, f, b < a, c, s[15:0]};
    endfunction

    function automatic logic cond_ref(input logic [3:0] c, input logic [4:0] fl);
        case (c)
            4'h0: return fl[3];
            4'h1: return !fl[3];
            4'h2: return fl[0];
            4'h3: return !fl[0];
            4'h4: return fl[2];
            4'h5: return !fl[2];
            4'h6: return !fl[4] && !fl[3];
            4'h7: return !fl[4];
            4'h8: return !fl[1] && !fl[3];
            4'h9: return !fl[1];
            4'hA: return fl[4];
            4'hB: return fl[4] || fl[3];
            4'hC: return fl[1];
            4'hD: return fl[1] || fl[3];
            4'hE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // ISA-level interpreter producing the expected store sequence
    function automatic void cr16_ref_run();
        logic [15:0] rm [256];
        logic [15:0] r [16];
        logic [4:0]  fl;
        logic [15:0] rpc;
        logic [15:0] iw;
        logic [15:0] nxt;
        logic [20:0] out;
        logic [3:0]  op;
        logic [3:0]  rd;
        logic [3:0]  ex;
        logic [3:0]  rs;
        logic [15:0] sx;
        int          sel;
        int          steps;
        bit          halted;
        for (int i = 0; i < 256; i++)
            rm[i] = image[i];
        for (int i = 0; i < 16; i++)
            r[i] = '0;
        fl = '0;
        rpc = '0;
        halted = 0;
        steps = 0;
        while (!halted && steps < 2000) begin
            iw = rm[rpc[7:0]];
            rpc = rpc + 16'd1;
            {op, rd, ex, rs} = iw;
            sx = {{8{iw[7]}}, iw[7:0]};
            sel = -1;
            case (op)
                4'h0: sel = (ex == 4'h0) ? 0 : (ex == 4'h1) ? 1 :
                            (ex == 4'h3 || ex == 4'h4) ? 2 : (ex == 4'h6) ? 3 :
                            (ex == 4'h7) ? 4 : (ex == 4'h8) ? 5 : -1;
                4'h1: sel = 0;
                4'h2: sel = 1;
                4'h4, 4'h5: sel = 2;
                4'h7: sel = 3;
                4'h8: sel = 4;
                4'h9: sel = 5;
                4'hA: r[rd] = {r[rd][15:8], iw[7:0]};
                4'hB: r[rd] = {iw[7:0], r[rd][7:0]};
                4'hC: begin
                    if (cond_ref(rd, fl)) begin
                        nxt = rpc + sx;
                        halted = (nxt == rpc - 16'd1);
                        rpc = nxt;
                    end
                end
                4'hF: begin
                    if (ex == 4'h1)
                        r[rd] = r[rs];
                    else if (ex == 4'h2 && cond_ref(rd, fl))
                        rpc = r[rs];
                    else if (ex == 4'hA)
                        r[rd] = rm[r[rs][7:0]];
                    else if (ex == 4'hB) begin
                        rm[r[rd][7:0]] = r[rs];
                        exp_addr.push_back(r[rd]);
                        exp_data.push_back(r[rs]);
                    end
                end
                default: ;
            endcase
            if (sel >= 0) begin
                if (op == 4'h0)
                    out = alu_ref(sel, r[rd], r[rs], fl[0]);
                else if (sel >= 3)
                    out = alu_ref(sel, r[rd], {8'h00, iw[7:0]}, fl[0]);
                else
                    out = alu_ref(sel, r[rd], sx, fl[0]);
                fl = out[20:16];
                // CMP and CMPI leave the destination alone
                if (!(op == 4'h5 || (op == 4'h0 && ex == 4'h4)))
                    r[rd] = out[15:0];
            end
            steps++;
        end
    endfunction

    // Every write is checked in order against the reference
    always @(posedge I_CLK) begin
        if (I_NRESET) begin
            if (!enable)
                check_value("mem_req.we", {15'd0, mem_req.we}, 16'h0000);
            if (mem_req.we) begin
                if (store_cnt >= exp_addr.size()) begin
                    $display("Store to %h beyond the expected sequence", mem_req.addr);
                    $display("SIMULATION FAILED");
                    $fatal(1);
                end
                check_value("mem_req.addr", mem_req.addr, exp_addr[store_cnt]);
                check_value("mem_req.wdata", mem_req.wdata, exp_data[store_cnt]);
                // A STORE passes register B through the ALU
                check_value("result_bus", result_bus, exp_data[store_cnt]);
                store_cnt++;
            end
        end
    end

    initial begin
        int gap;
        int stretch;
        int stay;
        int cycles;
        I_NRESET  = 1'b0;
        enable    = 1'b1;
        store_cnt = 0;
        pc_w      = 0;
        for (int i = 0; i < 256; i++)
            image[i] = 16'(i * 16'h0103) ^ 16'h5AC3;
        for (int i = 128; i < 136; i++)
            image[i] = 16'($random(seed));
        // r1 points to the data and r2 to the store area
        emit(enc(4'hA, 4'd1, 8'h80));
        emit(enc(4'hA, 4'd2, 8'h90));
        for (int i = 3; i <= 8; i++) begin
            emit(enc(4'hF, 4'(i), 8'hA1));
            emit(enc(4'h1, 4'd1, 8'h01));
        end
        emit(enc(4'hF, 4'd9, 8'h13));
        emit(enc(4'h0, 4'd9, 8'h04));
        store_reg(4'd9);
        // Carry chain across a 32-bit add
        emit(enc(4'hF, 4'd10, 8'h13));
        emit(enc(4'h0, 4'd10, 8'h05));
        emit(enc(4'hF, 4'd11, 8'h14));
        emit(enc(4'h0, 4'd11, 8'h16));
        store_reg(4'd10);
        store_reg(4'd11);
        for (int e = 0; e < 4; e++) begin
            emit(enc(4'hF, 4'd9, 8'h13));
            emit(enc(4'h0, 4'd9, {(e == 0) ? 4'h3 : 4'(e + 5), 4'd4}));
            store_reg(4'd9);
        end
        emit(enc(4'hF, 4'd9, 8'h13));
        emit(enc(4'h1, 4'd9, 8'hFB));
        store_reg(4'd9);
        emit(enc(4'h4, 4'd9, 8'h80));
        store_reg(4'd9);
        emit(enc(4'h7, 4'd9, 8'hF0));
        store_reg(4'd9);
        emit(enc(4'h8, 4'd9, 8'h81));
        store_reg(4'd9);
        emit(enc(4'h9, 4'd9, 8'hC3));
        store_reg(4'd9);
        emit(enc(4'hA, 4'd12, 8'h34));
        emit(enc(4'hB, 4'd12, 8'h12));
        emit(enc(4'hF, 4'd13, 8'h1C));
        store_reg(4'd13);
        emit(enc(4'hF, 4'd14, 8'hA1));
        store_reg(4'd14);
        cmp_branch(enc(4'h0, 4'd4, 8'h43), 4'h9, 8'h10);
        cmp_branch(enc(4'h0, 4'd3, 8'h43), 4'h0, 8'h12);
        cmp_branch(enc(4'h5, 4'd5, 8'h10), 4'h1, 8'h14);
        cmp_branch(enc(4'h0, 4'd3, 8'h44), 4'h2, 8'h16);
        cmp_branch(enc(4'h0, 4'd4, 8'h45), 4'h6, 8'h18);
        cmp_branch(enc(4'h5, 4'd6, 8'h7F), 4'hB, 8'h1A);
        cmp_branch(enc(4'h0, 4'd7, 8'h48), 4'hC, 8'h1C);
        store_reg(4'd7);
        // Register jump over a store that must not happen
        emit(enc(4'hA, 4'd9, 8'(pc_w + 5)));
        emit(enc(4'hB, 4'd9, 8'h00));
        emit(enc(4'hF, 4'hE, 8'h29));
        store_reg(4'd13);
        halt_addr = 16'(pc_w);
        emit(enc(4'hC, 4'hE, 8'hFF));
        for (int i = 0; i < 256; i++)
            mem[i] <= image[i];
        cr16_ref_run();
        gap     = 20 + int'({$random(seed)} % 40);
        stretch = 5 + int'({$random(seed)} % 16);
        repeat (10) @(negedge I_CLK);
        check_value("pc", pc, `CR16_RESET_PC);
        check_value("status_flags", {11'd0, status_flags}, 16'h0000);
        I_NRESET = 1'b1;
        repeat (gap) @(negedge I_CLK);
        enable = 1'b0;
        repeat (stretch) @(negedge I_CLK);
        enable = 1'b1;
        stay   = 0;
        cycles = 0;
        while (stay < 20 && cycles < 3000) begin
            @(negedge I_CLK);
            cycles++;
            if (pc == halt_addr || pc == halt_addr + 16'd1)
                stay++;
            else
                stay = 0;
        end
        if (stay < 20) begin
            $display("Timeout: the program never reached its halt loop");
            $display("SIMULATION FAILED");
            $fatal(1);
        end
        if (store_cnt == exp_addr.size()) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("Store count %0d, expected %0d", store_cnt, exp_addr.size());
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* cr16.f */
+incdir+source
source/cr16_pkg.sv
source/cr16_decoder.sv
source/cr16_control.sv
source/cr16_regfile.sv
source/cr16_alu.sv
source/cr16_core.sv
dv/cr16_sva.sv
dv/cr16_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CR16 testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f cr16.f --top-module cr16_tb -o Vcr16_tb; then
    echo "Verilator build failed"
    exit 1
fi

if ! obj_dir/Vcr16_tb > "$LOG" 2>&1; then
    echo "Simulator returned a failing status"
fi

cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "No pass message in $LOG"
    exit 1
fi

exit 0
